// ==== Makefile ====
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      ?= tb_vecmat_dot
FILELIST ?= verilog.f
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log
PASS_MSG := *** TEST PASSED ***

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test build clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

test: build
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hdl/vecmat_add_tree.sv ====
`default_nettype none

`include "vecmat_consts.svh"

module vecmat_add_tree #(
	parameter int lanes = `VECMAT_LANES
) (
	input wire clk,
	input wire reset,
	input wire mul_valid,
	input wire [lanes*`VECMAT_LANE_W-1:0] mul_prod,
	input wire mul_sat,
	input wire sum_ready,
	output logic mul_ready,
	output logic sum_valid,
	output vecmat_pkg::acc_t sum_acc,
	output logic sum_sat
);

	import vecmat_pkg::*;

	localparam int depth = $clog2(lanes);
	localparam int w = `VECMAT_LANE_W;

	// index k is the input of level k, index depth the tree output
	wire [depth:0] vld_c;
	wire [depth:0] sat_c;
	wire [depth:0] rdy_c;

	assign vld_c[0] = mul_valid;
	assign sat_c[0] = mul_sat;
	assign rdy_c[depth] = sum_ready;

	for (genvar k = 0; k < depth; k++) begin : g_lvl
		localparam int n = lanes >> (k + 1);

		logic vld_q;
		logic sat_q;
		acc_t sum_d [n];
		acc_t sum_q [n];

		// level moves when empty or when the next one takes it
		assign rdy_c[k] = !vld_q || rdy_c[k+1];
		assign vld_c[k+1] = vld_q;
		assign sat_c[k+1] = sat_q;

		for (genvar j = 0; j < n; j++) begin : g_node
			if (k == 0) begin : g_leaf
				lane_t a;
				lane_t b;

				assign a = mul_prod[(2*j)*w +: w];
				assign b = mul_prod[(2*j+1)*w +: w];
				assign sum_d[j] = acc_t'(a) + acc_t'(b); // sign extended
			end else begin : g_inner
				assign sum_d[j] = g_lvl[k-1].sum_q[2*j] + g_lvl[k-1].sum_q[2*j+1];
			end
		end

		always_ff @(posedge clk) begin
			if (!reset) begin
				vld_q <= 1'b0;
			end else if (rdy_c[k]) begin
				vld_q <= vld_c[k];
			end
		end

		always_ff @(posedge clk) begin
			if (rdy_c[k] && vld_c[k]) begin
				sum_q <= sum_d;
				sat_q <= sat_c[k]; // lane clamp flag rides along
			end
		end
	end

	assign mul_ready = rdy_c[0];
	assign sum_valid = vld_c[depth];
	assign sum_sat = sat_c[depth];
	assign sum_acc = g_lvl[depth-1].sum_q[0];

	// the root only fills from the level below it
	a_tree_order: assert property (
		@(posedge clk) disable iff (!reset)
		$rose(sum_valid) |-> $past(vld_c[depth-1])
	);

endmodule

`default_nettype wire

// ==== hdl/vecmat_consts.svh ====
`ifndef VECMAT_CONSTS_SVH
`define VECMAT_CONSTS_SVH

// hidden neurons per row
`define VECMAT_LANES 64

// Q8.8 lane
`define VECMAT_LANE_W 16
`define VECMAT_FRAC 8

// log2 of the lane count
`define VECMAT_TREE_DEPTH 6

// one bit of growth per tree level, plus a guard bit
`define VECMAT_ACC_W (`VECMAT_LANE_W + `VECMAT_TREE_DEPTH + 1)

// flat vector bus
`define VECMAT_VEC_W (`VECMAT_LANES * `VECMAT_LANE_W)

`endif

// ==== hdl/vecmat_dot.sv ====
`default_nettype none

`include "vecmat_consts.svh"

module vecmat_dot (
	input wire clk,
	input wire reset,
	input wire in_valid,
	input wire [`VECMAT_VEC_W-1:0] hidden_vec,
	input wire [`VECMAT_VEC_W-1:0] weight_row,
	output logic in_ready,
	output logic out_valid,
	output vecmat_pkg::lane_t dot_out,
	output logic saturated,
	input wire out_ready
);

	import vecmat_pkg::*;

	logic op_valid;
	logic op_ready;
	logic [`VECMAT_VEC_W-1:0] op_vec;
	logic [`VECMAT_VEC_W-1:0] op_row;

	logic mul_valid;
	logic mul_ready;
	logic [`VECMAT_VEC_W-1:0] mul_prod;
	logic mul_sat;

	logic sum_valid;
	logic sum_ready;
	acc_t sum_acc;
	logic sum_sat;

	vecmat_operand_stage i_operand (
		.clk(clk), .reset(reset),
		.in_valid(in_valid), .hidden_vec(hidden_vec), .weight_row(weight_row),
		.op_ready(op_ready), .in_ready(in_ready),
		.op_valid(op_valid), .op_vec(op_vec), .op_row(op_row)
	);

	vecmat_mul_stage i_mul (
		.clk(clk), .reset(reset),
		.op_valid(op_valid), .op_vec(op_vec), .op_row(op_row),
		.mul_ready(mul_ready), .op_ready(op_ready),
		.mul_valid(mul_valid), .mul_prod(mul_prod), .mul_sat(mul_sat)
	);

	vecmat_add_tree #(.lanes(`VECMAT_LANES)) i_tree (
		.clk(clk), .reset(reset),
		.mul_valid(mul_valid), .mul_prod(mul_prod), .mul_sat(mul_sat),
		.sum_ready(sum_ready), .mul_ready(mul_ready),
		.sum_valid(sum_valid), .sum_acc(sum_acc), .sum_sat(sum_sat)
	);

	vecmat_out_stage i_out (
		.clk(clk), .reset(reset),
		.sum_valid(sum_valid), .sum_acc(sum_acc), .sum_sat(sum_sat),
		.out_ready(out_ready), .sum_ready(sum_ready),
		.out_valid(out_valid), .dot_out(dot_out), .saturated(saturated)
	);

endmodule

`default_nettype wire

// ==== hdl/vecmat_mul_stage.sv ====
`default_nettype none

`include "vecmat_consts.svh"

module vecmat_mul_stage (
	input wire clk,
	input wire reset,
	input wire op_valid,
	input wire [`VECMAT_VEC_W-1:0] op_vec,
	input wire [`VECMAT_VEC_W-1:0] op_row,
	input wire mul_ready,
	output logic op_ready,
	output logic mul_valid,
	output logic [`VECMAT_VEC_W-1:0] mul_prod,
	output logic mul_sat
);

	import vecmat_pkg::*;

	localparam int w = `VECMAT_LANE_W;
	localparam prod_t sat_hi = (prod_t'(1) <<< (w - 1)) - 1;
	localparam prod_t sat_lo = -(prod_t'(1) <<< (w - 1));

	logic [`VECMAT_VEC_W-1:0] lane_q; // rescaled, clamped lanes
	logic [`VECMAT_LANES-1:0] lane_sat;

	for (genvar i = 0; i < `VECMAT_LANES; i++) begin : g_lane
		lane_t a;
		lane_t b;
		prod_t p;
		prod_t s;

		assign a = op_vec[i*w +: w];
		assign b = op_row[i*w +: w];
		assign p = a * b;
		assign s = p >>> `VECMAT_FRAC; // back to Q8.8, floors

		assign lane_sat[i] = (s > sat_hi) || (s < sat_lo);
		assign lane_q[i*w +: w] = (s > sat_hi) ? sat_hi[w-1:0] :
			(s < sat_lo) ? sat_lo[w-1:0] : s[w-1:0];
	end

	assign op_ready = !mul_valid || mul_ready;

	always_ff @(posedge clk) begin
		if (!reset) begin
			mul_valid <= 1'b0;
		end else if (op_ready) begin
			mul_valid <= op_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (op_ready && op_valid) begin
			mul_prod <= lane_q;
			mul_sat <= |lane_sat; // any lane clamped
		end
	end

	a_mul_reset: assert property (
		@(posedge clk)
		!reset |=> !mul_valid
	);

endmodule

`default_nettype wire

// ==== hdl/vecmat_operand_stage.sv ====
`default_nettype none

`include "vecmat_consts.svh"

module vecmat_operand_stage (
	input wire clk,
	input wire reset,
	input wire in_valid,
	input wire [`VECMAT_VEC_W-1:0] hidden_vec,
	input wire [`VECMAT_VEC_W-1:0] weight_row,
	input wire op_ready,
	output logic in_ready,
	output logic op_valid,
	output logic [`VECMAT_VEC_W-1:0] op_vec,
	output logic [`VECMAT_VEC_W-1:0] op_row
);

	logic take; // input transfer this edge

	assign in_ready = !op_valid || op_ready; // empty or draining
	assign take = in_valid && in_ready;

	always_ff @(posedge clk) begin
		if (!reset) begin
			op_valid <= 1'b0;
		end else if (in_ready) begin
			op_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			op_vec <= hidden_vec;
			op_row <= weight_row;
		end
	end

	// a stalled pair must not change under the multiplier
	a_op_hold: assert property (
		@(posedge clk) disable iff (!reset)
		op_valid && !op_ready |=> $stable(op_vec)
	);

endmodule

`default_nettype wire

// ==== hdl/vecmat_out_stage.sv ====
`default_nettype none

`include "vecmat_consts.svh"

module vecmat_out_stage (
	input wire clk,
	input wire reset,
	input wire sum_valid,
	input wire vecmat_pkg::acc_t sum_acc,
	input wire sum_sat,
	input wire out_ready,
	output logic sum_ready,
	output logic out_valid,
	output vecmat_pkg::lane_t dot_out,
	output logic saturated
);

	import vecmat_pkg::*;

	localparam int w = `VECMAT_LANE_W;
	localparam acc_t out_hi = (acc_t'(1) <<< (w - 1)) - 1;
	localparam acc_t out_lo = -(acc_t'(1) <<< (w - 1));

	logic clip_hi;
	logic clip_lo;
	lane_t clamped;

	assign clip_hi = sum_acc > out_hi;
	assign clip_lo = sum_acc < out_lo;
	assign clamped = clip_hi ? out_hi[w-1:0] : clip_lo ? out_lo[w-1:0] : sum_acc[w-1:0];

	assign sum_ready = !out_valid || out_ready;

	always_ff @(posedge clk) begin
		if (!reset) begin
			out_valid <= 1'b0;
		end else if (sum_ready) begin
			out_valid <= sum_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (sum_ready && sum_valid) begin
			dot_out <= clamped;
			saturated <= clip_hi || clip_lo || sum_sat; // row or lane clamp
		end
	end

	a_out_hold: assert property (
		@(posedge clk) disable iff (!reset)
		out_valid && !out_ready |=> $stable(dot_out)
	);

endmodule

`default_nettype wire

// ==== hdl/vecmat_pkg.sv ====
`default_nettype none

`include "vecmat_consts.svh"

package vecmat_pkg;

	// one signed Q8.8 lane
	typedef logic signed [`VECMAT_LANE_W-1:0] lane_t;

	// full product of two lanes, Q16.16
	typedef logic signed [2*`VECMAT_LANE_W-1:0] prod_t;

	// tree sum, wide enough that no level can overflow
	typedef logic signed [`VECMAT_ACC_W-1:0] acc_t;

endpackage

`default_nettype wire

// ==== testbench/tb_vecmat_dot.sv ====
`default_nettype none

`include "vecmat_consts.svh"

module tb_vecmat_dot;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int vec_w = `VECMAT_VEC_W;
	localparam int lane_w = `VECMAT_LANE_W;
	localparam int latency = 9; // transfer edge minus accept edge, out_ready high
	localparam int max_cycles = 4000;

	logic clk;
	logic reset;
	logic in_valid;
	logic [vec_w-1:0] hidden_vec;
	logic [vec_w-1:0] weight_row;
	logic in_ready;
	logic out_valid;
	logic signed [lane_w-1:0] dot_out;
	logic saturated;
	logic out_ready;

	// expected results, oldest first
	logic signed [lane_w-1:0] dot_q[$];
	logic sat_q[$];
	int edge_q[$];

	logic head_ok;
	logic signed [lane_w-1:0] exp_dot;
	logic exp_sat;
	int exp_lat;
	logic signed [lane_w-1:0] m_dot;
	logic m_sat;

	int cyc;
	int test_id;
	string test_name;
	logic lat_mode;
	int errors;
	int test_errs;
	int tests_run;
	int tests_failed;
	int sent;
	logic took;
	logic [vec_w-1:0] v_tmp;
	logic [vec_w-1:0] r_tmp;

	vecmat_dot i_dut (
		.clk(clk), .reset(reset),
		.in_valid(in_valid), .hidden_vec(hidden_vec), .weight_row(weight_row),
		.in_ready(in_ready),
		.out_valid(out_valid), .dot_out(dot_out), .saturated(saturated),
		.out_ready(out_ready)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc = cyc + 1;
		if (cyc >= max_cycles) begin
			$display("timeout: run did not finish within %0d cycles", max_cycles);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// Q8.8 lane product floored, each lane clamped, exact sum clamped once more
	function automatic void dot_model(input logic [vec_w-1:0] v, input logic [vec_w-1:0] r,
			output logic signed [lane_w-1:0] d, output logic s);
		logic signed [lane_w-1:0] a;
		logic signed [lane_w-1:0] b;
		longint p;
		longint acc;
		s = 1'b0;
		acc = 0;
		for (int i = 0; i < `VECMAT_LANES; i++) begin
			a = v[i*lane_w +: lane_w];
			b = r[i*lane_w +: lane_w];
			p = (longint'(a) * longint'(b)) >>> `VECMAT_FRAC;
			if (p > 32767) begin
				p = 32767;
				s = 1'b1;
			end else if (p < -32768) begin
				p = -32768;
				s = 1'b1;
			end
			acc = acc + p;
		end
		if (acc > 32767) begin
			acc = 32767;
			s = 1'b1;
		end else if (acc < -32768) begin
			acc = -32768;
			s = 1'b1;
		end
		d = 16'(acc);
	endfunction

	function automatic logic [vec_w-1:0] rand_vec(input int lo, input int hi);
		logic [vec_w-1:0] v;
		for (int i = 0; i < `VECMAT_LANES; i++) begin
			v[i*lane_w +: lane_w] = 16'(lo + int'($urandom_range(0, hi - lo)));
		end
		return v;
	endfunction

	// inputs and outputs are stable here, so this sees the next edge's transfers
	always @(negedge clk) begin
		head_ok = dot_q.size() > 0;
		if (head_ok) begin
			exp_dot = dot_q[0];
			exp_sat = sat_q[0];
			exp_lat = cyc + 1 - edge_q[0];
			if (out_valid && out_ready) begin
				void'(dot_q.pop_front());
				void'(sat_q.pop_front());
				void'(edge_q.pop_front());
			end
		end
		if (reset && in_valid && in_ready) begin
			dot_model(hidden_vec, weight_row, m_dot, m_sat);
			dot_q.push_back(m_dot);
			sat_q.push_back(m_sat);
			edge_q.push_back(cyc + 1);
		end
	end

	task automatic value_error(input string what, input int expv, input int actv);
		$display("FAIL %s %s: expected %0d, actual %0d", test_name, what, expv, actv);
		errors++;
		test_errs++;
	endtask

	task automatic plain_error(input string msg);
		$display("error in test %s: %s", test_name, msg);
		errors++;
		test_errs++;
	endtask

	a_reset: assert property (@(posedge clk) !reset && cyc > 0 |-> !out_valid && in_ready)
		else plain_error("out_valid high or in_ready low during reset");
	a_reset_exit: assert property (@(posedge clk) $rose(reset) |-> !out_valid && in_ready)
		else plain_error("out_valid high or in_ready low right after reset");
	a_spurious: assert property (@(posedge clk) disable iff (!reset)
		out_valid && out_ready |-> head_ok)
		else plain_error("result delivered with no pair outstanding");
	a_dot: assert property (@(posedge clk) disable iff (!reset)
		out_valid && out_ready && head_ok |-> dot_out == exp_dot)
		else value_error("dot_out", int'($sampled(exp_dot)), int'($sampled(dot_out)));
	a_sat: assert property (@(posedge clk) disable iff (!reset)
		out_valid && out_ready && head_ok |-> saturated == exp_sat)
		else value_error("saturated", int'($sampled(exp_sat)), int'($sampled(saturated)));
	a_clean: assert property (@(posedge clk) test_id == 2 && out_valid && out_ready |-> !saturated)
		else value_error("saturated", 0, int'($sampled(saturated)));
	a_flagged: assert property (@(posedge clk) test_id == 3 && out_valid && out_ready |-> saturated)
		else value_error("saturated", 1, int'($sampled(saturated)));
	a_latency: assert property (@(posedge clk) lat_mode && out_valid && out_ready && head_ok
		|-> exp_lat == latency)
		else value_error("latency", latency, $sampled(exp_lat));
	a_b2b: assert property (@(posedge clk) lat_mode && in_valid |-> in_ready)
		else plain_error("in_ready fell while out_ready was held high");
	a_hold: assert property (@(posedge clk) disable iff (!reset)
		out_valid && !out_ready |=> out_valid && $stable(dot_out) && $stable(saturated))
		else plain_error("result dropped or changed while stalled");

	task automatic start_test(input int id, input string name);
		test_id = id;
		test_name = name;
		test_errs = 0;
	endtask

	task automatic finish_test();
		tests_run++;
		if (test_errs != 0) begin
			tests_failed++;
		end
		$display("test %0d %s: %0d errors", test_id, test_name, test_errs);
		test_id = 0;
	endtask

	// present one pair and hold it until the DUT takes it
	task automatic send_pair(input logic [vec_w-1:0] v, input logic [vec_w-1:0] r);
		in_valid = 1'b1;
		hidden_vec = v;
		weight_row = r;
		@(negedge clk);
		while (!in_ready) begin
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic drain();
		while (dot_q.size() != 0) begin
			@(negedge clk);
		end
		@(posedge clk);
		#1;
	endtask

	initial begin
		void'($urandom(32'hbef6_5bf1));
		cyc = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		reset = 1'b0;
		in_valid = 1'b0;
		hidden_vec = '0;
		weight_row = '0;
		out_ready = 1'b1;
		lat_mode = 1'b0;
		head_ok = 1'b0;
		exp_dot = '0;
		exp_sat = 1'b0;
		exp_lat = 0;
		start_test(1, "reset");
		repeat (8) @(posedge clk);
		#1 reset = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		finish_test();

		start_test(2, "exact_products");
		for (int n = 0; n < 50; n++) begin
			send_pair(rand_vec(-256, 255), rand_vec(-256, 255));
		end
		drain();
		finish_test();

		start_test(3, "saturation");
		send_pair({`VECMAT_LANES{16'h4000}}, {`VECMAT_LANES{16'h0400}}); // 64.0 * 4.0
		send_pair({`VECMAT_LANES{16'h8000}}, {`VECMAT_LANES{16'h8000}});
		send_pair({`VECMAT_LANES{16'h7fff}}, {`VECMAT_LANES{16'h8000}});
		v_tmp = '0;
		v_tmp[lane_w-1:0] = 16'h4000; // one clamped lane, sum in range
		send_pair(v_tmp, {`VECMAT_LANES{16'h0400}});
		send_pair({`VECMAT_LANES{16'h0b00}}, {`VECMAT_LANES{16'h0b00}}); // 121 per lane
		send_pair({`VECMAT_LANES{16'h0b00}}, {`VECMAT_LANES{16'hf500}});
		for (int n = 0; n < 4; n++) begin
			v_tmp = rand_vec(16'h0a00, 16'h0b00);
			r_tmp = (n % 2 == 0) ? rand_vec(16'h0a00, 16'h0b00) : rand_vec(-16'h0b00, -16'h0a00);
			send_pair(v_tmp, r_tmp);
		end
		drain();
		finish_test();

		start_test(4, "latency_throughput");
		lat_mode = 1'b1;
		for (int n = 0; n < 20; n++) begin
			send_pair(rand_vec(-256, 255), rand_vec(-256, 255));
		end
		drain();
		lat_mode = 1'b0;
		finish_test();

		start_test(5, "back_pressure");
		sent = 0;
		while (sent < 300 || dot_q.size() != 0) begin
			out_ready = $urandom_range(0, 99) >= 40;
			if (!in_valid && sent < 300 && $urandom_range(0, 3) != 0) begin
				in_valid = 1'b1;
				if ($urandom_range(0, 1) == 1) begin
					hidden_vec = rand_vec(-32768, 32767);
					weight_row = rand_vec(-32768, 32767);
				end else begin
					hidden_vec = rand_vec(-256, 255);
					weight_row = rand_vec(-256, 255);
				end
			end
			@(negedge clk);
			took = in_valid && in_ready;
			if (took) begin
				sent++;
			end
			@(posedge clk);
			#1;
			if (took) begin
				in_valid = 1'b0;
			end
		end
		out_ready = 1'b1;
		finish_test();

		repeat (2) @(posedge clk);
		$display("tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hdl
hdl/vecmat_pkg.sv
hdl/vecmat_operand_stage.sv
hdl/vecmat_mul_stage.sv
hdl/vecmat_add_tree.sv
hdl/vecmat_out_stage.sv
hdl/vecmat_dot.sv
testbench/tb_vecmat_dot.sv
